/* Bender.yml */
package:
  name: singleCycleCpu

sources:
  - files:
      - hw/mipsPkg.sv
      - hw/cpuPkg.sv
      - hw/wordMemory.sv
      - hw/mainControl.sv
      - hw/regFile.sv
      - hw/alu.sv
      - hw/pcUnit.sv
      - hw/singleCycleCpu.sv
  - target: test
    files:
      - tb/cpuMonitor.sv
      - tb/singleCycleCpu_chk.sv
      - tb/singleCycleCpuTb.sv

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpuPkg::aluOpT op,
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    output logic [31:0]   result,
    output logic          zero
);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            // Signed compare
            cpuPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
            default:        result = '0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOpT;

    // Destination register choice
    typedef enum logic [1:0] {
        destRt,
        destRd,
        destRa
    } destSelT;

    typedef struct packed {
        logic    regWrite;
        destSelT destSel;
        logic    aluSrcImm;
        logic    memWrite;
        logic    memToReg;
        logic    linkWrite;
        logic    branchEq;
        logic    branchNe;
        logic    jump;
        logic    jumpReg;
        aluOpT   aluOp;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbT;

    // Word address, not byte address
    typedef struct packed {
        logic        valid;
        logic [29:0] addr;
        logic [31:0] data;
    } storeT;

endpackage

`default_nettype wire

/* hw/mainControl.sv */
`timescale 1ns/10ps
`default_nettype none

module mainControl (
    input  mipsPkg::instrT instr,
    output cpuPkg::ctrlT   ctrl,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [4:0]     rd,
    output logic [31:0]    imm,
    output logic [25:0]    jumpTarget
);

    assign rs = instr.r.rs;
    assign rt = instr.r.rt;
    assign rd = instr.r.rd;
    assign imm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign jumpTarget = instr.j.target;

    always_comb begin
        // Everything off, so unknown encodings do nothing
        ctrl = '0;
        case (instr.r.opcode)
            mipsPkg::opSpecial: begin
                ctrl.destSel = cpuPkg::destRd;
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    mipsPkg::fnAdd: ctrl.aluOp = cpuPkg::aluAdd;
                    mipsPkg::fnSub: ctrl.aluOp = cpuPkg::aluSub;
                    mipsPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
                    mipsPkg::fnOr:  ctrl.aluOp = cpuPkg::aluOr;
                    mipsPkg::fnXor: ctrl.aluOp = cpuPkg::aluXor;
                    mipsPkg::fnSlt: ctrl.aluOp = cpuPkg::aluSlt;
                    mipsPkg::fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            // Branches compare by subtraction and test the zero flag
            mipsPkg::opBeq: begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp = cpuPkg::aluSub;
            end
            mipsPkg::opBne: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp = cpuPkg::aluSub;
            end
            mipsPkg::opJ: ctrl.jump = 1'b1;
            mipsPkg::opJal: begin
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.destSel = cpuPkg::destRa;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // Major opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddi    = 6'h08,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // Function codes under opSpecial
    typedef enum logic [5:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target;
    } jTypeT;

    // One instruction word, three field layouts
    typedef union packed {
        rTypeT       r;
        iTypeT       i;
        jTypeT       j;
        logic [31:0] raw;
    } instrT;

endpackage

`default_nettype wire

/* hw/pcUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module pcUnit (
    input  logic         clk,
    input  logic         rst,
    input  cpuPkg::ctrlT ctrl,
    input  logic         zero,
    input  logic [31:0]  imm,
    input  logic [25:0]  jumpTarget,
    input  logic [31:0]  regTarget,
    output logic [31:0]  pc,
    output logic [31:0]  pcPlus4
);

    logic [31:0] branchAddr;
    logic [31:0] jumpAddr;
    logic [31:0] pcNext;
    logic        taken;

    assign pcPlus4 = pc + 32'd4;
    assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};
    assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};
    assign taken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

    // jr wins over j/jal, which win over branches
    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = regTarget;
        end else if (ctrl.jump) begin
            pcNext = jumpAddr;
        end else if (taken) begin
            pcNext = branchAddr;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is hardwired
    assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

`default_nettype wire

/* hw/singleCycleCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module singleCycleCpu #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256,
    localparam int imemAddrBits = $clog2(imemWords),
    localparam int dmemAddrBits = $clog2(dmemWords)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    imemWe,
    input  logic [imemAddrBits-1:0] imemAddr,
    input  logic [31:0]             imemData,
    output cpuPkg::wbT              wb,
    output cpuPkg::storeT           store,
    output logic [31:0]             pc
);

    mipsPkg::instrT          instr;
    cpuPkg::ctrlT            ctrl;
    logic [imemAddrBits-1:0] fetchAddr;
    logic [4:0]              rs;
    logic [4:0]              rt;
    logic [4:0]              rd;
    logic [4:0]              destAddr;
    logic [31:0]             imm;
    logic [25:0]             jumpTarget;
    logic [31:0]             rdataA;
    logic [31:0]             rdataB;
    logic [31:0]             aluB;
    logic [31:0]             aluResult;
    logic                    zero;
    logic [31:0]             loadData;
    logic [31:0]             wbData;
    logic [31:0]             pcPlus4;
    logic                    dmemWe;

    // Loader owns the instruction memory while reset is held
    assign fetchAddr = rst ? imemAddr : pc[2 +: imemAddrBits];

    wordMemory #(.words(imemWords)) imem (
        .clk(clk), .we(imemWe), .addr(fetchAddr), .wdata(imemData), .rdata(instr)
    );

    mainControl control (
        .instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .rd(rd),
        .imm(imm), .jumpTarget(jumpTarget)
    );

    always_comb begin
        case (ctrl.destSel)
            cpuPkg::destRd: destAddr = rd;
            cpuPkg::destRa: destAddr = 5'd31;
            default:        destAddr = rt;
        endcase
    end

    assign wbData = ctrl.linkWrite ? pcPlus4 : (ctrl.memToReg ? loadData : aluResult);

    regFile regs (
        .clk(clk), .rst(rst), .we(ctrl.regWrite), .waddr(destAddr), .wdata(wbData),
        .raddrA(rs), .raddrB(rt), .rdataA(rdataA), .rdataB(rdataB)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rdataB;

    alu alu0 (.op(ctrl.aluOp), .a(rdataA), .b(aluB), .result(aluResult), .zero(zero));

    // No stores while the program is being loaded
    assign dmemWe = ctrl.memWrite & ~rst;

    wordMemory #(.words(dmemWords)) dmem (
        .clk(clk), .we(dmemWe), .addr(aluResult[2 +: dmemAddrBits]),
        .wdata(rdataB), .rdata(loadData)
    );

    pcUnit pcu (
        .clk(clk), .rst(rst), .ctrl(ctrl), .zero(zero), .imm(imm),
        .jumpTarget(jumpTarget), .regTarget(rdataA), .pc(pc), .pcPlus4(pcPlus4)
    );

    // Writes to r0 are dropped by the register file, so not reported
    assign wb.valid = ctrl.regWrite & (destAddr != 5'd0) & ~rst;
    assign wb.addr = destAddr;
    assign wb.data = wbData;

    assign store.valid = dmemWe;
    assign store.addr = aluResult[31:2];
    assign store.data = rdataB;

endmodule

`default_nettype wire

/* hw/wordMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module wordMemory #(
    parameter int words = 256,
    localparam int addrBits = $clog2(words)
) (
    input  logic                clk,
    input  logic                we,
    input  logic [addrBits-1:0] addr,
    input  logic [31:0]         wdata,
    output logic [31:0]         rdata
);

    logic [31:0] mem [words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read is combinational so the fetch and load fit in one cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* singleCycleCpu.f */
hw/mipsPkg.sv
hw/cpuPkg.sv
hw/wordMemory.sv
hw/mainControl.sv
hw/regFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/singleCycleCpu.sv
tb/cpuMonitor.sv
tb/singleCycleCpu_chk.sv
tb/singleCycleCpuTb.sv

/* tb/cpuMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuMonitor #(
    parameter int numExpected = 1
) (
    input  logic          clk,
    input  logic          rst,
    input  cpuPkg::wbT    wb,
    input  cpuPkg::storeT store,
    input  logic [62:0]   expected [numExpected],
    input  logic          finished,
    output int            errorCount,
    output int            seenCount
);

    int   index;
    logic missingChecked;

    initial begin
        errorCount = 0;
        seenCount = 0;
        index = 0;
        missingChecked = 1'b0;
    end

    task automatic compareValue(input string name, input logic [31:0] want,
                                input logic [31:0] got);
        if (got !== want) begin
            $display("error: time %0t signal %s expected %h got %h", $time, name, want, got);
            errorCount++;
        end
    endtask

    task automatic checkEvent(input logic isStore, input logic [29:0] addr,
                              input logic [31:0] data);
        logic [62:0] entry;
        string       kind;
        kind = isStore ? "store" : "register write";
        if (index >= numExpected) begin
            $display("unexpected %s at time %0t after the last expected event", kind, $time);
            errorCount++;
        end else begin
            entry = expected[index];
            seenCount++;
            if (entry[62] != isStore) begin
                $display("event %0d at time %0t is a %s, which the table does not expect",
                         index, $time, kind);
                errorCount++;
            end else begin
                compareValue(isStore ? "store.addr" : "wb.addr", {2'b00, entry[61:32]},
                             {2'b00, addr});
                compareValue(isStore ? "store.data" : "wb.data", entry[31:0], data);
            end
            index++;
        end
    endtask

    // Outputs settle between edges, so sample the pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (wb.valid) begin
                checkEvent(1'b0, {25'd0, wb.addr}, wb.data);
            end
            if (store.valid) begin
                checkEvent(1'b1, store.addr, store.data);
            end
        end
        if (finished && !missingChecked) begin
            missingChecked = 1'b1;
            if (index < numExpected) begin
                $display("missing events: only %0d of %0d expected events arrived",
                         index, numExpected);
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/singleCycleCpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module singleCycleCpuTb;

    localparam int imemWords = 256;
    localparam int dmemWords = 256;
    localparam int addrBits = $clog2(imemWords);
    localparam int period = 8;
    localparam int resetCycles = 4;
    localparam int numProg = 29;
    localparam int numExpected = 20;
    // Final j-to-self sits at word 26
    localparam logic [31:0] haltAddr = 32'd104;
    // Loading, reset, every word executed twice, plus margin
    localparam int timeoutCycles = numProg + resetCycles + 2 * numProg + 100;

    logic                clk;
    logic                rst;
    logic                imemWe;
    logic [addrBits-1:0] imemAddr;
    logic [31:0]         imemData;
    cpuPkg::wbT          wb;
    cpuPkg::storeT       store;
    logic [31:0]         pc;
    logic                finished;
    int                  errorCount;
    int                  seenCount;
    logic [31:0]         progWords [numProg];
    logic [62:0]         expected [numExpected];

    function automatic logic [31:0] encodeR(mipsPkg::functT funct, logic [4:0] rs,
                                            logic [4:0] rt, logic [4:0] rd);
        mipsPkg::instrT w;
        w.r.opcode = mipsPkg::opSpecial;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.rd = rd;
        w.r.shamt = 5'd0;
        w.r.funct = funct;
        return w.raw;
    endfunction

    function automatic logic [31:0] encodeI(mipsPkg::opcodeT op, logic [4:0] rs,
                                            logic [4:0] rt, logic [15:0] imm);
        mipsPkg::instrT w;
        w.i.opcode = op;
        w.i.rs = rs;
        w.i.rt = rt;
        w.i.imm = imm;
        return w.raw;
    endfunction

    function automatic logic [31:0] encodeJ(mipsPkg::opcodeT op, logic [25:0] target);
        mipsPkg::instrT w;
        w.j.opcode = op;
        w.j.target = target;
        return w.raw;
    endfunction

    // Entry layout is kind bit, 30-bit address, 32-bit data
    function automatic logic [62:0] wbEvent(logic [4:0] r, logic [31:0] d);
        return {1'b0, 25'd0, r, d};
    endfunction

    function automatic logic [62:0] storeEvent(logic [29:0] a, logic [31:0] d);
        return {1'b1, a, d};
    endfunction

    task automatic fillTables();
        // ALU results, with -3 and -1 as operands
        progWords[0] = encodeI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5);
        progWords[1] = encodeI(mipsPkg::opAddi, 5'd0, 5'd2, 16'hfffd);
        progWords[2] = encodeR(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd3);
        progWords[3] = encodeR(mipsPkg::fnSub, 5'd2, 5'd1, 5'd4);
        progWords[4] = encodeI(mipsPkg::opAddi, 5'd0, 5'd5, 16'h7fff);
        progWords[5] = encodeR(mipsPkg::fnAnd, 5'd2, 5'd5, 5'd6);
        progWords[6] = encodeR(mipsPkg::fnOr, 5'd1, 5'd2, 5'd7);
        progWords[7] = encodeR(mipsPkg::fnXor, 5'd2, 5'd5, 5'd8);
        progWords[8] = encodeR(mipsPkg::fnSlt, 5'd2, 5'd1, 5'd9);
        progWords[9] = encodeR(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd10);
        progWords[10] = encodeI(mipsPkg::opAddi, 5'd0, 5'd11, 16'hffff);
        progWords[11] = encodeR(mipsPkg::fnAdd, 5'd11, 5'd1, 5'd12);
        // Write to r0, then read it back
        progWords[12] = encodeI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd7);
        progWords[13] = encodeR(mipsPkg::fnAdd, 5'd0, 5'd1, 5'd13);
        progWords[14] = encodeI(mipsPkg::opSw, 5'd12, 5'd8, 16'd8);
        progWords[15] = encodeI(mipsPkg::opLw, 5'd0, 5'd14, 16'd12);
        // Branches, each followed by a marker
        progWords[16] = encodeI(mipsPkg::opBeq, 5'd1, 5'd13, 16'd1);
        progWords[17] = encodeI(mipsPkg::opAddi, 5'd0, 5'd15, 16'd1);
        progWords[18] = encodeI(mipsPkg::opBeq, 5'd1, 5'd2, 16'd1);
        progWords[19] = encodeI(mipsPkg::opAddi, 5'd0, 5'd16, 16'd2);
        progWords[20] = encodeI(mipsPkg::opBne, 5'd1, 5'd2, 16'd1);
        progWords[21] = encodeI(mipsPkg::opAddi, 5'd0, 5'd17, 16'd3);
        progWords[22] = encodeI(mipsPkg::opBne, 5'd1, 5'd13, 16'd1);
        progWords[23] = encodeI(mipsPkg::opAddi, 5'd0, 5'd18, 16'd4);
        // Call to word 27 and return
        progWords[24] = encodeJ(mipsPkg::opJal, 26'd27);
        progWords[25] = encodeI(mipsPkg::opAddi, 5'd0, 5'd19, 16'd6);
        progWords[26] = encodeJ(mipsPkg::opJ, 26'd26);
        progWords[27] = encodeI(mipsPkg::opAddi, 5'd0, 5'd20, 16'd9);
        progWords[28] = encodeR(mipsPkg::fnJr, 5'd31, 5'd0, 5'd0);

        expected[0] = wbEvent(5'd1, 32'h0000_0005);
        expected[1] = wbEvent(5'd2, 32'hffff_fffd);
        expected[2] = wbEvent(5'd3, 32'h0000_0002);
        expected[3] = wbEvent(5'd4, 32'hffff_fff8);
        expected[4] = wbEvent(5'd5, 32'h0000_7fff);
        expected[5] = wbEvent(5'd6, 32'h0000_7ffd);
        expected[6] = wbEvent(5'd7, 32'hffff_fffd);
        expected[7] = wbEvent(5'd8, 32'hffff_8002);
        expected[8] = wbEvent(5'd9, 32'h0000_0001);
        expected[9] = wbEvent(5'd10, 32'h0000_0000);
        expected[10] = wbEvent(5'd11, 32'hffff_ffff);
        // Wraps past 2**32
        expected[11] = wbEvent(5'd12, 32'h0000_0004);
        expected[12] = wbEvent(5'd13, 32'h0000_0005);
        expected[13] = storeEvent(30'd3, 32'hffff_8002);
        expected[14] = wbEvent(5'd14, 32'hffff_8002);
        expected[15] = wbEvent(5'd16, 32'h0000_0002);
        expected[16] = wbEvent(5'd18, 32'h0000_0004);
        expected[17] = wbEvent(5'd31, 32'h0000_0064);
        expected[18] = wbEvent(5'd20, 32'h0000_0009);
        expected[19] = wbEvent(5'd19, 32'h0000_0006);
    endtask

    singleCycleCpu #(.imemWords(imemWords), .dmemWords(dmemWords)) DUT (
        .clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wb(wb), .store(store), .pc(pc)
    );

    cpuMonitor #(.numExpected(numExpected)) monitor (
        .clk(clk), .rst(rst), .wb(wb), .store(store), .expected(expected),
        .finished(finished), .errorCount(errorCount), .seenCount(seenCount)
    );

    always #(period / 2) clk = ~clk;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        finished = 1'b0;
        fillTables();
        for (int k = 0; k < numProg; k++) begin
            @(negedge clk);
            imemWe = 1'b1;
            imemAddr = k[addrBits-1:0];
            imemData = progWords[k];
        end
        @(negedge clk);
        imemWe = 1'b0;
        repeat (resetCycles - 1) @(negedge clk);
        rst = 1'b0;
        while (pc !== haltAddr) @(negedge clk);
        // A few laps of the final loop, which must stay silent
        repeat (4) @(negedge clk);
        finished = 1'b1;
        repeat (2) @(negedge clk);
        $display("errors: %0d, assertion failures: %0d, events seen: %0d of %0d",
                 errorCount, DUT.chk.failCount, seenCount, numExpected);
        if (errorCount == 0 && DUT.chk.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeoutCycles * period);
        $display("timeout: the program did not reach its final jump in %0d cycles",
                 timeoutCycles);
        $display("errors: %0d, assertion failures: %0d, events seen: %0d of %0d",
                 errorCount, DUT.chk.failCount, seenCount, numExpected);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/singleCycleCpu_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module singleCycleCpuChk (
    input logic          clk,
    input logic          rst,
    input logic          imemWe,
    input cpuPkg::wbT    wb,
    input cpuPkg::storeT store,
    input logic [31:0]   pc
);

    // Failures seen so far, read by the testbench at the end of the run
    int failCount = 0;

    silentInReset: assert property (@(posedge clk) rst |-> !wb.valid && !store.valid)
        else begin
            $error("report strobe active during reset");
            failCount++;
        end

    noZeroWrite: assert property (@(posedge clk) disable iff (rst) wb.valid |-> wb.addr != 5'd0)
        else begin
            $error("register write reported for r0");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            $error("program counter not word aligned");
            failCount++;
        end

    loadOnlyInReset: assert property (@(posedge clk) !rst |-> !imemWe)
        else begin
            $error("instruction memory load outside reset");
            failCount++;
        end

endmodule

bind singleCycleCpu singleCycleCpuChk chk (
    .clk(clk), .rst(rst), .imemWe(imemWe), .wb(wb), .store(store), .pc(pc)
);

`default_nettype wire
